// ==== dds_mod.f ====
hdl/dds_sig_pkg.sv
hdl/dds_reg_pkg.sv
hdl/dds_apb_regs.sv
hdl/dds_waveform.sv
hdl/symbol_lfsr.sv
hdl/mod_combiner.sv
hdl/dds_mod_top.sv
dv/dds_mod_checker.sv
dv/tb_dds_mod.sv

// ==== dv/dds_mod_checker.sv ====
`timescale 1ns/10ps

module dds_mod_checker #(
   parameter int unsigned SYMBOL_DIV = 16
) (
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  dds_reg_pkg::apb_req_t apb_req,
   input  dds_reg_pkg::apb_rsp_t apb_rsp,
   input  dds_sig_pkg::sample_t  carrier_out,
   input  dds_sig_pkg::sample_t  modulated_out,
   input  logic [4:0]            lfsr_state,
   input  logic                  exp_check,
   input  logic                  exp_err,
   input  logic [31:0]           exp_data,
   input  logic [8*24-1:0]       test_name,
   output int                    errors
);
   import dds_sig_pkg::*;
   import dds_reg_pkg::*;

   logic [11:0] sine_tab [64];
   logic [2:0]  m_mode    = '0;
   logic [1:0]  m_carrier = '0;
   logic [31:0] m_tune    = '0;
   logic [31:0] m_phase   = '0;
   logic [11:0] m_sin     = '0;
   logic [11:0] m_cos     = '0;
   logic [11:0] m_squ     = '0;
   logic [11:0] m_saw     = '0;
   logic [4:0]  m_lfsr    = 5'b00001;
   int          m_cnt     = 0;
   logic [11:0] exp_car   = '0;   // what the outputs show after the next edge
   logic [11:0] exp_mod   = '0;

   initial begin
      errors = 0;
      for (int i = 0; i < 64; i++) begin
         sine_tab[i] = 12'($rtoi(2048.0 + 2047.0 * $sin(2.0 * 3.14159265358979 *
                                 (i + 0.5) / 64.0) + 0.5));
      end
   end

   task automatic compare(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("error %0s %0s expected %h actual %h", test_name, what, expected, actual);
      end
   endtask

   function automatic logic [11:0] invert(input logic [11:0] x);
      return 12'd4095 - x;
   endfunction

   function automatic logic [11:0] modulate(input logic [2:0] mode, input logic [1:0] sym,
                                            input logic [11:0] s, input logic [11:0] c);
      case (mode)
         3'd0:    return sym[0] ? s : 12'd0;
         3'd1:    return s;
         3'd2:    return sym[0] ? s : invert(s);
         3'd3:    return sym[0] ? 12'd0 : 12'd2048;
         3'd4: begin
            case (sym)
               2'd0:    return c;
               2'd1:    return invert(s);
               2'd2:    return invert(c);
               default: return s;
            endcase
         end
         default: return 12'd0;
      endcase
   endfunction

   ////////////////////
   // compare, then step the model
   ////////////////////

   always @(posedge CLK_25MHZ) begin
      logic       access;
      logic [5:0] idx;
      access = apb_req.psel && apb_req.penable;
      if (!reset_from_key) begin
         compare("carrier_out", exp_car, carrier_out);
         compare("modulated_out", exp_mod, modulated_out);
         compare("lfsr_state", m_lfsr, lfsr_state);
         if (access) begin
            compare("pready", 32'd1, apb_rsp.pready);
            if (exp_check) compare("pslverr", exp_err, apb_rsp.pslverr);
            if (exp_check && !exp_err && !apb_req.pwrite) begin
               compare("prdata", (apb_req.paddr == SYMBOL_ADDR) ? m_lfsr : exp_data,
                       apb_rsp.prdata);
            end
         end
      end
      if (reset_from_key) begin
         exp_car = '0;
         exp_mod = '0;
      end else begin
         case (m_carrier)
            2'd0:    exp_car = m_sin;
            2'd1:    exp_car = m_cos;
            2'd2:    exp_car = m_saw;
            default: exp_car = m_squ;
         endcase
         exp_mod = modulate(m_mode, m_lfsr[1:0], m_sin, m_cos);
      end
      idx   = m_phase[31:26];
      m_sin = sine_tab[idx];
      idx   = idx + 6'd16;   // cosine leads by a quarter
      m_cos = sine_tab[idx];
      m_squ = m_phase[31] ? 12'd0 : 12'd4095;
      m_saw = m_phase[31:20];
      m_phase = reset_from_key ? 32'd0 : m_phase + m_tune;
      if (reset_from_key) begin
         m_lfsr = 5'b00001;
         m_cnt  = 0;
      end else if (m_cnt == SYMBOL_DIV - 1) begin
         m_cnt  = 0;
         m_lfsr = {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
      end else begin
         m_cnt++;
      end
      if (reset_from_key) begin
         m_mode    = '0;
         m_carrier = '0;
         m_tune    = '0;
      end else if (access && apb_req.pwrite) begin
         if (apb_req.paddr == CTRL_ADDR) begin
            m_mode    = apb_req.pwdata[2:0];
            m_carrier = apb_req.pwdata[5:4];
         end else if (apb_req.paddr == TUNE_ADDR) begin
            m_tune = apb_req.pwdata;
         end
      end
   end

endmodule

// ==== dv/dds_mod_testdata.txt ====
# op test_name addr value, all numbers in hex
# op w writes, r reads and compares (lfsr reads use the model), e expects pslverr, n runs cycles
r reset_ctrl      00 00000000
r reset_tune      04 00000000
w tune_write      04 0147ae14
w ctrl_all_ones   00 ffffffff
r ctrl_masked     00 00000037
e symbol_write    08 0000001f
e unmapped_write  10 12345678
r tune_unchanged  04 0147ae14
w ask_sin         00 00000000
n ask_sin_run     00 00000100
w fsk_cos         00 00000011
n fsk_cos_run     00 00000080
w bpsk_saw        00 00000022
n bpsk_saw_run    00 00000080
w tune_fast       04 08000000
w lfsr_square     00 00000033
n lfsr_square_run 00 00000080
r symbol_read     08 00000000
w qpsk_sin        00 00000004
n qpsk_run        00 00000190
w illegal_mode    00 00000005
n illegal_run     00 00000020

// ==== dv/tb_dds_mod.sv ====
`timescale 1ns/10ps

module tb_dds_mod;
   import dds_sig_pkg::*;
   import dds_reg_pkg::*;

   localparam int unsigned SYMBOL_DIV = 16;   // fast symbols for simulation
   localparam int          CLK_NS     = 40;

   logic            CLK_25MHZ = 1'b0;
   logic            reset_from_key;
   apb_req_t        apb_req;
   apb_rsp_t        apb_rsp;
   sample_t         carrier_out;
   sample_t         modulated_out;
   logic [4:0]      lfsr_state;

   logic            exp_check;   // checker looks at this access
   logic            exp_err;
   apb_data_t       exp_data;
   logic [8*24-1:0] test_name;
   int              check_errors;

   // one entry per data file line
   logic [8*8-1:0]  op_q[$];
   logic [8*24-1:0] name_q[$];
   logic [31:0]     addr_q[$];
   logic [31:0]     value_q[$];
   longint          limit_ns   = 0;
   int              pass_count = 0;
   int              fail_count = 0;

   always #(CLK_NS/2) CLK_25MHZ = ~CLK_25MHZ;

   dds_mod_top #(.SYMBOL_DIV(SYMBOL_DIV)) dut (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .apb_req        (apb_req),
      .apb_rsp        (apb_rsp),
      .carrier_out    (carrier_out),
      .modulated_out  (modulated_out),
      .lfsr_state     (lfsr_state)
   );

   dds_mod_checker #(.SYMBOL_DIV(SYMBOL_DIV)) u_checker (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .apb_req        (apb_req),
      .apb_rsp        (apb_rsp),
      .carrier_out    (carrier_out),
      .modulated_out  (modulated_out),
      .lfsr_state     (lfsr_state),
      .exp_check      (exp_check),
      .exp_err        (exp_err),
      .exp_data       (exp_data),
      .test_name      (test_name),
      .errors         (check_errors)
   );

   ////////////////////
   // data file
   ////////////////////

   task automatic load_tests(output longint run_cycles);
      int              fd;
      int              n;
      logic [8*96-1:0] line;
      logic [8*8-1:0]  op;
      logic [8*24-1:0] name;
      logic [31:0]     addr;
      logic [31:0]     value;
      run_cycles = 0;
      fd = $fopen("dv/dds_mod_testdata.txt", "r");
      if (fd == 0) begin
         $display("cannot open the test data file dv/dds_mod_testdata.txt");
         fail_count++;
      end else begin
         while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%s %s %h %h", op, name, addr, value) == 4
                && op != "#") begin
               op_q.push_back(op);
               name_q.push_back(name);
               addr_q.push_back(addr);
               value_q.push_back(value);
               if (op == "n") run_cycles += value;
            end
         end
         $fclose(fd);
      end
   endtask

   ////////////////////
   // apb master
   ////////////////////

   // setup on one falling edge, access on the next
   task automatic apb_transfer(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic err,
                               input logic [31:0] rdata);
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = apb_addr_t'(addr);
      apb_req.pwdata  = wdata;
      exp_err         = err;
      exp_data        = rdata;
      exp_check       = 1'b1;
      @(negedge CLK_25MHZ);
      apb_req.penable = 1'b1;
      @(posedge CLK_25MHZ);
      while (!apb_rsp.pready) @(posedge CLK_25MHZ);   // wait states, if any
      @(negedge CLK_25MHZ);
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
      exp_check       = 1'b0;
   endtask

   task automatic run_test(input logic [8*8-1:0] op, input logic [8*24-1:0] name,
                           input logic [31:0] addr, input logic [31:0] value);
      int   errors_before;
      logic bad;
      bad           = 1'b0;
      errors_before = check_errors;
      test_name     = name;
      case (op)
         "w":     apb_transfer(1'b1, addr, value, 1'b0, value);
         "r":     apb_transfer(1'b0, addr, '0, 1'b0, value);
         "e":     apb_transfer(1'b1, addr, value, 1'b1, '0);   // slave error expected
         "n":     repeat (value) @(negedge CLK_25MHZ);
         default: begin
            $display("test %0s has an unknown command %0s", name, op);
            bad = 1'b1;
         end
      endcase
      if (bad || check_errors != errors_before) begin
         fail_count++;
         $display("%0s failed", name);
      end else begin
         pass_count++;
         $display("%0s passed", name);
      end
   endtask

   initial begin
      longint run_cycles;
      reset_from_key = 1'b1;
      apb_req        = '0;
      exp_check      = 1'b0;
      exp_err        = 1'b0;
      exp_data       = '0;
      test_name      = "reset";
      load_tests(run_cycles);
      limit_ns = (run_cycles + 10 * op_q.size()) * CLK_NS * 2;
      repeat (4) @(posedge CLK_25MHZ);
      @(negedge CLK_25MHZ);
      reset_from_key = 1'b0;
      foreach (op_q[i]) run_test(op_q[i], name_q[i], addr_q[i], value_q[i]);
      $display("tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // watchdog
   initial begin
      wait (limit_ns > 0);
      #(limit_ns);
      $display("timeout, the tests did not finish within %0d ns", limit_ns);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== hdl/dds_apb_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module dds_apb_regs (
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  dds_reg_pkg::apb_req_t apb_req,
   output dds_reg_pkg::apb_rsp_t apb_rsp,
   input  logic [4:0]            lfsr_state,
   output dds_reg_pkg::mod_cfg_t cfg
);
   import dds_sig_pkg::*;
   import dds_reg_pkg::*;

   logic      access;    // second cycle of a transfer
   logic      addr_ok;
   logic      wr_err;
   logic      wr_en;
   apb_data_t rd_data;

   assign access  = apb_req.psel && apb_req.penable;
   assign addr_ok = (apb_req.paddr == CTRL_ADDR) || (apb_req.paddr == TUNE_ADDR) ||
                    (apb_req.paddr == SYMBOL_ADDR);
   assign wr_err  = apb_req.pwrite && (apb_req.paddr == SYMBOL_ADDR);   // status is read only
   assign wr_en   = access && apb_req.pwrite && addr_ok && !wr_err;

   ////////////////////
   // config registers
   ////////////////////

   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         cfg <= '{mode: ASK, carrier: SIN, tune: '0};
      end else if (wr_en) begin
         case (apb_req.paddr)
            CTRL_ADDR: begin
               cfg.mode    <= mod_mode_e'(apb_req.pwdata[2:0]);    // illegal codes kept as is
               cfg.carrier <= carrier_sel_e'(apb_req.pwdata[5:4]);
            end
            TUNE_ADDR: cfg.tune <= phase_t'(apb_req.pwdata);
            default: ;
         endcase
      end
   end

   ////////////////////
   // readback
   ////////////////////

   always_comb begin
      rd_data = '0;
      case (apb_req.paddr)
         CTRL_ADDR: begin
            rd_data[2:0] = cfg.mode;
            rd_data[5:4] = cfg.carrier;
         end
         TUNE_ADDR:   rd_data = cfg.tune;
         SYMBOL_ADDR: rd_data[4:0] = lfsr_state;
         default:     rd_data = '0;
      endcase
   end

   // no wait states, errors only in the access cycle
   always_comb begin
      apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_data : '0;
      apb_rsp.pready  = 1'b1;
      apb_rsp.pslverr = access && (!addr_ok || wr_err);
   end

   // access phase must come straight after a setup phase
   a_setup_first: assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      apb_req.penable |-> $past(apb_req.psel) && !$past(apb_req.penable)
   ) else $error("apb penable without setup cycle");

   a_addr_stable: assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      access |-> $stable(apb_req.paddr)
   ) else $error("apb paddr changed between setup and access");

endmodule

`default_nettype wire

// ==== hdl/dds_mod_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dds_mod_top #(
   parameter int unsigned SYMBOL_DIV = 25_000_000   // clocks per symbol step
) (
   input  logic                  CLK_25MHZ,
   input  logic                  reset_from_key,
   input  dds_reg_pkg::apb_req_t apb_req,
   output dds_reg_pkg::apb_rsp_t apb_rsp,
   output dds_sig_pkg::sample_t  carrier_out,
   output dds_sig_pkg::sample_t  modulated_out,
   output logic [4:0]            lfsr_state
);
   import dds_sig_pkg::*;
   import dds_reg_pkg::*;

   mod_cfg_t     cfg;        // mode, carrier, tune
   carrier_bus_t carriers;

   ////////////////////
   // control
   ////////////////////

   dds_apb_regs u_regs (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .apb_req        (apb_req),
      .apb_rsp        (apb_rsp),
      .lfsr_state     (lfsr_state),   // status readback
      .cfg            (cfg)
   );

   ////////////////////
   // sources
   ////////////////////

   dds_waveform u_dds (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .tune           (cfg.tune),
      .carriers       (carriers)
   );

   symbol_lfsr #(
      .SYMBOL_DIV (SYMBOL_DIV)
   ) u_symbols (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_state     (lfsr_state)
   );

   // output stage
   mod_combiner u_combiner (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .carriers       (carriers),
      .lfsr_state     (lfsr_state),
      .mode           (cfg.mode),
      .carrier        (cfg.carrier),
      .carrier_out    (carrier_out),
      .modulated_out  (modulated_out)
   );

endmodule

`default_nettype wire

// ==== hdl/dds_reg_pkg.sv ====
package dds_reg_pkg;

   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      apb_data_t prdata;
      logic      pready;
      logic      pslverr;
   } apb_rsp_t;

   ////////////////////
   // register map
   ////////////////////
   localparam apb_addr_t CTRL_ADDR   = 8'h00;   // [2:0] mode, [5:4] carrier
   localparam apb_addr_t TUNE_ADDR   = 8'h04;   // phase increment
   localparam apb_addr_t SYMBOL_ADDR = 8'h08;   // lfsr state, read only

   typedef struct packed {
      dds_sig_pkg::mod_mode_e    mode;
      dds_sig_pkg::carrier_sel_e carrier;
      dds_sig_pkg::phase_t       tune;
   } mod_cfg_t;

endpackage

// ==== hdl/dds_sig_pkg.sv ====
package dds_sig_pkg;

   ////////////////////
   // sample widths
   ////////////////////

   localparam int PHASE_W  = 32;
   localparam int SAMPLE_W = 12;
   localparam int SYMBOL_W = 2;

   typedef logic [PHASE_W-1:0]  phase_t;    // accumulator and tuning word
   typedef logic [SAMPLE_W-1:0] sample_t;   // offset binary
   typedef logic [SYMBOL_W-1:0] symbol_t;   // two low lfsr bits

   localparam sample_t SAMPLE_MID = sample_t'(2048);   // zero level
   localparam sample_t SAMPLE_MAX = '1;

   ////////////////////
   // selector encodings
   ////////////////////

   // codes 5..7 are illegal and give a zero output
   typedef enum logic [2:0] {
      ASK  = 3'd0,
      FSK  = 3'd1,
      BPSK = 3'd2,
      LFSR = 3'd3,
      QPSK = 3'd4
   } mod_mode_e;

   typedef enum logic [1:0] {
      SIN    = 2'd0,
      COS    = 2'd1,
      SAW    = 2'd2,
      SQUARE = 2'd3
   } carrier_sel_e;

   // all four dds waveforms, same sample instant
   typedef struct packed {
      sample_t sin;
      sample_t cos;
      sample_t squ;
      sample_t saw;
   } carrier_bus_t;

endpackage

// ==== hdl/dds_waveform.sv ====
`timescale 1ns/10ps
`default_nettype none

module dds_waveform (
   input  logic                      CLK_25MHZ,
   input  logic                      reset_from_key,
   input  dds_sig_pkg::phase_t       tune,
   output dds_sig_pkg::carrier_bus_t carriers
);
   import dds_sig_pkg::*;

   typedef logic [5:0]  table_idx_t;   // 64 entry sine table
   typedef logic [10:0] quarter_amp_t;

   phase_t     phase;
   table_idx_t sin_idx;
   table_idx_t cos_idx;

   ////////////////////
   // sine table
   ////////////////////

   // first quarter, round(2047*sin) at the middle of each step
   function automatic quarter_amp_t quarter_wave(input logic [3:0] k);
      quarter_amp_t amp;
      case (k)
         4'd0:    amp = 11'd100;
         4'd1:    amp = 11'd300;
         4'd2:    amp = 11'd497;
         4'd3:    amp = 11'd690;
         4'd4:    amp = 11'd875;
         4'd5:    amp = 11'd1052;
         4'd6:    amp = 11'd1219;
         4'd7:    amp = 11'd1375;
         4'd8:    amp = 11'd1517;
         4'd9:    amp = 11'd1644;
         4'd10:   amp = 11'd1756;
         4'd11:   amp = 11'd1850;
         4'd12:   amp = 11'd1927;
         4'd13:   amp = 11'd1986;
         4'd14:   amp = 11'd2025;
         default: amp = 11'd2045;
      endcase
      return amp;
   endfunction

   // rebuild the full period from one quarter
   function automatic sample_t sine_lookup(input table_idx_t idx);
      logic [3:0]   k;
      quarter_amp_t amp;
      k   = idx[4] ? ~idx[3:0] : idx[3:0];   // falling quarters run backwards
      amp = quarter_wave(k);
      if (idx[5]) begin
         return SAMPLE_MID - sample_t'(amp);   // negative half
      end
      return SAMPLE_MID + sample_t'(amp);
   endfunction

   ////////////////////
   // phase accumulator
   ////////////////////

   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         phase <= '0;
      end else begin
         phase <= phase + tune;   // wraps naturally
      end
   end

   assign sin_idx = phase[PHASE_W-1 -: 6];
   assign cos_idx = sin_idx + 6'd16;   // quarter turn ahead, mod 64

   // waveforms lag the phase by one edge
   always_ff @(posedge CLK_25MHZ) begin
      carriers.sin <= sine_lookup(sin_idx);
      carriers.cos <= sine_lookup(cos_idx);
      carriers.squ <= phase[PHASE_W-1] ? '0 : SAMPLE_MAX;   // high in first half
      carriers.saw <= phase[PHASE_W-1 -: SAMPLE_W];
   end

endmodule

`default_nettype wire

// ==== hdl/mod_combiner.sv ====
`timescale 1ns/10ps
`default_nettype none

module mod_combiner (
   input  logic                      CLK_25MHZ,
   input  logic                      reset_from_key,
   input  dds_sig_pkg::carrier_bus_t carriers,
   input  logic [4:0]                lfsr_state,
   input  dds_sig_pkg::mod_mode_e    mode,
   input  dds_sig_pkg::carrier_sel_e carrier,
   output dds_sig_pkg::sample_t      carrier_out,
   output dds_sig_pkg::sample_t      modulated_out
);
   import dds_sig_pkg::*;

   symbol_t sym;
   sample_t carrier_nxt;
   sample_t mod_nxt;

   assign sym = symbol_t'(lfsr_state[1:0]);

   ////////////////////
   // carrier select
   ////////////////////

   always_comb begin
      case (carrier)
         SIN:     carrier_nxt = carriers.sin;
         COS:     carrier_nxt = carriers.cos;
         SAW:     carrier_nxt = carriers.saw;
         SQUARE:  carrier_nxt = carriers.squ;
         default: carrier_nxt = '0;
      endcase
   end

   ////////////////////
   // modulation select
   ////////////////////

   // inversion of an offset binary sample is 4095 - x
   always_comb begin
      case (mode)
         ASK:  mod_nxt = sym[0] ? carriers.sin : '0;             // on-off keying
         FSK:  mod_nxt = carriers.sin;                           // frequency from tune
         BPSK: mod_nxt = sym[0] ? carriers.sin : ~carriers.sin;
         LFSR: mod_nxt = sym[0] ? '0 : SAMPLE_MID;               // raw symbol level
         QPSK: begin
            case (sym)
               2'b01:   mod_nxt = ~carriers.sin;
               2'b10:   mod_nxt = ~carriers.cos;
               2'b11:   mod_nxt = carriers.sin;
               default: mod_nxt = carriers.cos;   // symbol 00
            endcase
         end
         default: mod_nxt = '0;   // unused codes
      endcase
   end

   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         carrier_out   <= '0;
         modulated_out <= '0;
      end else begin
         carrier_out   <= carrier_nxt;
         modulated_out <= mod_nxt;
      end
   end

   // software can still program codes 5..7
   a_mode_legal: assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      mode inside {ASK, FSK, BPSK, LFSR, QPSK}
   ) else $warning("modulation mode %0d outside the defined set", mode);

endmodule

`default_nettype wire

// ==== hdl/symbol_lfsr.sv ====
`timescale 1ns/10ps
`default_nettype none

module symbol_lfsr #(
   parameter int unsigned SYMBOL_DIV = 25_000_000   // clocks per symbol
) (
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   output logic [4:0] lfsr_state
);
   localparam int unsigned      CNT_W    = (SYMBOL_DIV > 1) ? $clog2(SYMBOL_DIV) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SYMBOL_DIV - 1);
   localparam logic [4:0]       SEED     = 5'b00001;

   logic [CNT_W-1:0] div_cnt;
   logic             sym_step;   // one clock per symbol

   assign sym_step = (div_cnt == CNT_LAST);

   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         div_cnt <= '0;
      end else if (sym_step) begin
         div_cnt <= '0;
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // fibonacci form, taps 5 and 3
   always_ff @(posedge CLK_25MHZ) begin
      if (reset_from_key) begin
         lfsr_state <= SEED;
      end else if (sym_step) begin
         lfsr_state <= {lfsr_state[3:0], lfsr_state[4] ^ lfsr_state[2]};
      end
   end

   // all zero would lock the sequence
   a_never_zero: assert property (
      @(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_state != '0
   ) else $error("lfsr reached the all zero state");

endmodule

`default_nettype wire
